//--- design/alink_pkg.sv
`default_nettype none

package alink_pkg;

	localparam int PHY_NUM = 5;	// receive channels
	localparam int REC_WORDS = 5;	// words per report
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	// stop granting once a whole report might not fit
	localparam int ALMOST_FULL_LVL = FIFO_DEPTH - REC_WORDS;

	// marker in the upper half of the channel id word
	localparam logic [15:0] RXID_TAG = 16'ha11c;

	// one complete report, first word in the top bits
	typedef struct packed {
		logic [31:0] rxid;	// tag and channel index
		logic [31:0] task_h;
		logic [31:0] task_l;
		logic [31:0] timer;	// timer value at the last bit
		logic [31:0] nonce;
	} rx_record_t;

	// one word of a report stream
	typedef struct packed {
		logic        vld;
		logic        last;	// fifth word of a report
		logic [31:0] dat;
	} rx_beat_t;

endpackage

`default_nettype wire

//--- design/rx_phy.sv
`default_nettype none

module rx_phy #(
	parameter int MY_RXID = 0
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             reg_flush,
	input  wire logic             reg_busy,
	input  wire logic             task_id_vld,
	input  wire logic [31:0]      task_id_h,
	input  wire logic [31:0]      task_id_l,
	input  wire logic [31:0]      timer_cnt,
	input  wire logic             rx_p,
	input  wire logic             rx_n,
	input  wire logic             grant,
	output logic                  rx_start,
	output alink_pkg::rx_beat_t   beat
);
	import alink_pkg::*;

	logic        p_d;
	logic        n_d;
	logic        p_pulse;
	logic        n_pulse;
	logic        pulse;
	logic        done;
	logic        capture;
	logic        send;
	logic [4:0]  bit_cnt;
	logic [31:0] shreg;
	logic [31:0] nonce;
	logic [31:0] task_h_r;
	logic [31:0] task_l_r;
	rx_record_t  rec;
	logic [2:0]  widx;
	logic [31:0] word;

	// a pulse is the rising edge of a rail
	assign p_pulse = rx_p && !p_d;
	assign n_pulse = rx_n && !n_d;
	assign pulse = p_pulse || n_pulse;

	// lsb first, so new bits enter at the top
	assign nonce = {p_pulse, shreg[31:1]};
	assign done = pulse && (bit_cnt == 5'd31);
	assign capture = done && !rx_start && reg_busy;	// otherwise the nonce is dropped
	assign send = grant && rx_start;

	always_ff @(posedge clk) begin
		if (rst) begin
			p_d <= 1'b0;
			n_d <= 1'b0;
			bit_cnt <= 5'd0;
		end else begin
			p_d <= rx_p;
			n_d <= rx_n;
			if (pulse)
				bit_cnt <= bit_cnt + 5'd1;	// wraps after 32 bits
		end
	end

	always_ff @(posedge clk) begin
		if (pulse)
			shreg <= nonce;
		if (task_id_vld) begin
			task_h_r <= task_id_h;
			task_l_r <= task_id_l;
		end
		if (capture) begin
			rec.rxid <= {RXID_TAG, 16'(MY_RXID)};
			rec.task_h <= task_h_r;
			rec.task_l <= task_l_r;
			rec.timer <= timer_cnt;
			rec.nonce <= nonce;
		end
	end

	// report pending until its last word leaves
	always_ff @(posedge clk) begin
		if (rst || reg_flush) begin
			rx_start <= 1'b0;
			widx <= 3'd0;
		end else if (capture) begin
			rx_start <= 1'b1;
		end else if (send) begin
			if (widx == 3'(REC_WORDS - 1)) begin
				rx_start <= 1'b0;
				widx <= 3'd0;
			end else begin
				widx <= widx + 3'd1;
			end
		end
	end

	always_comb begin
		case (widx)
			3'd0:    word = rec.rxid;
			3'd1:    word = rec.task_h;
			3'd2:    word = rec.task_l;
			3'd3:    word = rec.timer;
			default: word = rec.nonce;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || reg_flush)
			beat.vld <= 1'b0;
		else
			beat.vld <= send;
		beat.last <= (widx == 3'(REC_WORDS - 1));
		beat.dat <= word;
	end

	// the line never drives both rails at once
	a_rails_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(rx_p && rx_n));

endmodule

`default_nettype wire

//--- design/rxc.sv
`default_nettype none

module rxc (
	input  wire logic                                        clk,
	input  wire logic                                        rst,
	input  wire logic                                        reg_flush,
	input  wire logic [alink_pkg::PHY_NUM-1:0]               reg_mask,
	input  wire logic                                        task_id_vld,
	input  wire logic [alink_pkg::PHY_NUM-1:0]               rx_phy_sel,
	input  wire logic [alink_pkg::PHY_NUM-1:0]               start_vec,
	input  wire alink_pkg::rx_beat_t [alink_pkg::PHY_NUM-1:0] beats,
	input  wire logic                                        almost_full,
	output logic [alink_pkg::PHY_NUM-1:0]                    grant_vec,
	output logic [alink_pkg::PHY_NUM-1:0]                    task_vld_vec,
	output alink_pkg::rx_beat_t                              out_beat
);
	import alink_pkg::*;

	logic [PHY_NUM-1:0] sel;
	logic [PHY_NUM-1:0] elig;
	logic [PHY_NUM-1:0] pick;
	logic [PHY_NUM-1:0] last_vec;
	rx_beat_t           sel_beat;

	// task ids go only to the addressed channels
	assign task_vld_vec = rx_phy_sel & {PHY_NUM{task_id_vld}};

	assign elig = start_vec & ~reg_mask;	// masked channels never win
	assign pick = elig & (~elig + 1'b1);	// lowest set bit

	always_comb begin
		for (int i = 0; i < PHY_NUM; i++)
			last_vec[i] = beats[i].vld && beats[i].last;
	end

	// one-hot select, held for the whole report
	always_ff @(posedge clk) begin
		if (rst || reg_flush)
			sel <= '0;
		else if (|(sel & last_vec))
			sel <= '0;
		else if (sel == '0 && !almost_full)
			sel <= pick;
	end

	assign grant_vec = sel;

	always_comb begin
		sel_beat = '0;
		for (int i = 0; i < PHY_NUM; i++) begin
			if (sel[i])
				sel_beat = beats[i];
		end
	end

	// one register stage toward the fifo
	always_ff @(posedge clk) begin
		if (rst || reg_flush)
			out_beat.vld <= 1'b0;
		else
			out_beat.vld <= sel_beat.vld;
		out_beat.last <= sel_beat.last;
		out_beat.dat <= sel_beat.dat;
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant_vec));

	// a new grant needs room for a whole report
	a_grant_room: assert property (@(posedge clk) disable iff (rst)
		$rose(|grant_vec) |-> !$past(almost_full));

endmodule

`default_nettype wire

//--- design/rx_fifo.sv
`default_nettype none

module rx_fifo (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                reg_flush,
	input  wire alink_pkg::rx_beat_t in_beat,
	output logic                     almost_full,
	input  wire logic                wb_cyc,
	input  wire logic                wb_stb,
	input  wire logic                wb_we,
	input  wire logic                wb_adr,
	input  wire logic [31:0]         wb_dat_i,
	output logic [31:0]              wb_dat_o,
	output logic                     wb_ack
);
	import alink_pkg::*;

	logic [31:0]        mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               access;
	logic               rd;
	logic               empty;
	logic               pop;

	assign access = wb_cyc && wb_stb && !wb_ack;	// ack never twice in a row
	assign rd = access && !wb_we;
	assign empty = (count == '0);
	assign pop = rd && !wb_adr && !empty;
	assign almost_full = (count >= (FIFO_AW + 1)'(ALMOST_FULL_LVL));

	always_ff @(posedge clk) begin
		if (in_beat.vld)
			mem[wr_ptr] <= in_beat.dat;
	end

	always_ff @(posedge clk) begin
		if (rst || reg_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_beat.vld)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (FIFO_AW + 1)'(in_beat.vld) - (FIFO_AW + 1)'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;
		if (rd) begin
			if (wb_adr)
				wb_dat_o <= 32'(count);	// status word
			else if (empty)
				wb_dat_o <= 32'd0;
			else
				wb_dat_o <= mem[rd_ptr];
		end
	end

	// collector only grants with room left
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		in_beat.vld |-> count != (FIFO_AW + 1)'(FIFO_DEPTH));

	a_wr_data_known: assert property (@(posedge clk) disable iff (rst)
		(access && wb_we) |-> !$isunknown(wb_dat_i));

endmodule

`default_nettype wire

//--- design/alink_rx_top.sv
`default_nettype none

module alink_rx_top (
	input  wire logic                                 clk,
	input  wire logic                                 rst,
	input  wire logic [alink_pkg::PHY_NUM-1:0]        rx_p,
	input  wire logic [alink_pkg::PHY_NUM-1:0]        rx_n,
	input  wire logic                                 reg_flush,
	input  wire logic [alink_pkg::PHY_NUM-1:0]        reg_mask,
	input  wire logic [alink_pkg::PHY_NUM-1:0]        reg_busy,
	input  wire logic                                 task_id_vld,
	input  wire logic [alink_pkg::PHY_NUM-1:0]        rx_phy_sel,
	input  wire logic [31:0]                          task_id_h,
	input  wire logic [31:0]                          task_id_l,
	input  wire logic [alink_pkg::PHY_NUM-1:0][31:0]  timer_cnt,
	input  wire logic                                 wb_cyc,
	input  wire logic                                 wb_stb,
	input  wire logic                                 wb_we,
	input  wire logic                                 wb_adr,
	input  wire logic [31:0]                          wb_dat_i,
	output logic [31:0]                               wb_dat_o,
	output logic                                      wb_ack
);
	import alink_pkg::*;

	logic [PHY_NUM-1:0]           start_vec;
	logic [PHY_NUM-1:0]           grant_vec;
	logic [PHY_NUM-1:0]           task_vld_vec;
	rx_beat_t [PHY_NUM-1:0]       beats;
	rx_beat_t                     fifo_beat;
	logic                         almost_full;

	// one decoder per channel
	for (genvar i = 0; i < PHY_NUM; i++) begin : g_phy
		rx_phy #(.MY_RXID(i)) u_phy (
			.clk         (clk),
			.rst         (rst),
			.reg_flush   (reg_flush),
			.reg_busy    (reg_busy[i]),
			.task_id_vld (task_vld_vec[i]),
			.task_id_h   (task_id_h),
			.task_id_l   (task_id_l),
			.timer_cnt   (timer_cnt[i]),
			.rx_p        (rx_p[i]),
			.rx_n        (rx_n[i]),
			.grant       (grant_vec[i]),
			.rx_start    (start_vec[i]),
			.beat        (beats[i])
		);
	end

	rxc u_rxc (
		.clk          (clk),
		.rst          (rst),
		.reg_flush    (reg_flush),
		.reg_mask     (reg_mask),
		.task_id_vld  (task_id_vld),
		.rx_phy_sel   (rx_phy_sel),
		.start_vec    (start_vec),
		.beats        (beats),
		.almost_full  (almost_full),
		.grant_vec    (grant_vec),
		.task_vld_vec (task_vld_vec),
		.out_beat     (fifo_beat)
	);

	rx_fifo u_fifo (
		.clk         (clk),
		.rst         (rst),
		.reg_flush   (reg_flush),
		.in_beat     (fifo_beat),
		.almost_full (almost_full),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack)
	);

endmodule

`default_nettype wire

//--- tests/rx_monitor.sv
`default_nettype none

module rx_monitor (
	input wire logic                                 clk,
	input wire logic                                 rst,
	input wire logic [alink_pkg::PHY_NUM-1:0]        rx_p,
	input wire logic [alink_pkg::PHY_NUM-1:0]        rx_n,
	input wire logic                                 reg_flush,
	input wire logic [alink_pkg::PHY_NUM-1:0]        reg_mask,
	input wire logic [alink_pkg::PHY_NUM-1:0]        reg_busy,
	input wire logic                                 task_id_vld,
	input wire logic [alink_pkg::PHY_NUM-1:0]        rx_phy_sel,
	input wire logic [31:0]                          task_id_h,
	input wire logic [31:0]                          task_id_l,
	input wire logic [alink_pkg::PHY_NUM-1:0][31:0]  timer_cnt,
	input wire logic                                 wb_cyc,
	input wire logic                                 wb_stb,
	input wire logic                                 wb_we,
	input wire logic                                 wb_adr,
	input wire logic [31:0]                          wb_dat_o,
	input wire logic                                 wb_ack
);
	import alink_pkg::*;

	int          errors = 0;
	logic        p_d [PHY_NUM];
	logic        n_d [PHY_NUM];
	logic [4:0]  bit_cnt [PHY_NUM];
	logic [31:0] shreg [PHY_NUM];
	logic [31:0] th [PHY_NUM];
	logic [31:0] tl [PHY_NUM];
	rx_record_t  exp_q [PHY_NUM][$];	// reports not yet read, per channel
	longint      done_q [PHY_NUM][$];	// cycle each report completed
	longint      cyc = 0;
	int          fifo_words;	// words the fifo should hold once settled
	int          waiting;	// unmasked reports not yet moved to the fifo
	int          cur_ch;
	int          widx;
	logic        exp_ack;
	logic        acc_we;
	logic        acc_adr;

	task automatic value_error(string name, logic [31:0] exp, logic [31:0] act);
		$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic text_error(string msg);
		$display("error at t=%0t: %s", $time, msg);
		errors++;
	endtask

	// grants go on while the fifo is below the almost full level
	task automatic settle();
		while (waiting > 0 && fifo_words < ALMOST_FULL_LVL) begin
			fifo_words += REC_WORDS;
			waiting--;
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < PHY_NUM; i++) begin
			exp_q[i].delete();
			done_q[i].delete();
		end
		fifo_words = 0;
		waiting = 0;
		cur_ch = 0;
		widx = 0;
	endtask

	task automatic check_word(logic [31:0] d);
		int          c;
		rx_record_t  r;
		logic [31:0] e;
		settle();
		if (widx == 0) begin
			if (fifo_words == 0) begin	// fifo should be empty
				if (d != 32'd0)
					value_error("wb_dat_o empty read", 32'd0, d);
				return;
			end
			c = int'(d[15:0]);
			if (d[31:16] != RXID_TAG)
				value_error("wb_dat_o rxid tag", {RXID_TAG, d[15:0]}, d);
			if (c >= PHY_NUM || exp_q[c].size() == 0) begin
				text_error("report read from a channel with no report pending");
				return;
			end
			if (reg_mask[c])
				text_error("report read from a masked channel");
			for (int j = 0; j < c; j++) begin
				if (exp_q[j].size() > 0 && !reg_mask[j] && done_q[j][0] <= done_q[c][0])
					text_error("report of a lower channel was overtaken");
			end
			cur_ch = c;
			widx = 1;
		end else begin
			r = exp_q[cur_ch][0];
			e = r[159 - 32 * widx -: 32];
			if (d != e)
				value_error("wb_dat_o", e, d);
			widx++;
			if (widx == REC_WORDS) begin
				exp_q[cur_ch].pop_front();
				void'(done_q[cur_ch].pop_front());
				widx = 0;
			end
		end
		if (fifo_words > 0)
			fifo_words--;
	endtask

	always @(posedge clk) begin
		cyc++;
		if (rst) begin
			clear_model();
			exp_ack = 1'b0;
			acc_we = 1'b0;
			acc_adr = 1'b0;
			for (int i = 0; i < PHY_NUM; i++) begin
				p_d[i] = 1'b0;
				n_d[i] = 1'b0;
				bit_cnt[i] = 5'd0;
			end
		end else begin
			if (wb_ack !== exp_ack)
				value_error("wb_ack", 32'(exp_ack), 32'(wb_ack));
			if (wb_ack && !acc_we) begin
				settle();
				if (acc_adr) begin
					if (wb_dat_o != 32'(fifo_words))
						value_error("wb_dat_o status", 32'(fifo_words), wb_dat_o);
				end else begin
					check_word(wb_dat_o);
				end
			end
			exp_ack = wb_cyc && wb_stb && !exp_ack;	// ack due next cycle, one per access
			if (exp_ack) begin
				acc_we = wb_we;
				acc_adr = wb_adr;
			end
			if (reg_flush)
				clear_model();
			for (int i = 0; i < PHY_NUM; i++) begin
				if ((rx_p[i] && !p_d[i]) || (rx_n[i] && !n_d[i])) begin
					shreg[i] = {rx_p[i] && !p_d[i], shreg[i][31:1]};
					if (bit_cnt[i] == 5'd31 && reg_busy[i] && !reg_flush) begin
						exp_q[i].push_back({RXID_TAG, 16'(i), th[i], tl[i], timer_cnt[i],
							shreg[i]});
						done_q[i].push_back(cyc);
						if (!reg_mask[i])
							waiting++;
					end
					bit_cnt[i] = bit_cnt[i] + 5'd1;
				end
				if (task_id_vld && rx_phy_sel[i]) begin	// after capture, old ids used
					th[i] = task_id_h;
					tl[i] = task_id_l;
				end
				p_d[i] = rx_p[i];
				n_d[i] = rx_n[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_alink_rx.sv
`default_nettype none

module tb_alink_rx;
	import alink_pkg::*;

	localparam int N_ROUNDS = 16;	// nonce rounds sent
	localparam int N_WORDS = 100;	// words read back
	localparam int MAX_CYCLES = N_ROUNDS * 32 * 6 + N_WORDS * 16 + N_ROUNDS * 200 + 2000;

	logic                        clk;
	logic                        rst;
	logic [PHY_NUM-1:0]          rx_p;
	logic [PHY_NUM-1:0]          rx_n;
	logic                        reg_flush;
	logic [PHY_NUM-1:0]          reg_mask;
	logic [PHY_NUM-1:0]          reg_busy;
	logic                        task_id_vld;
	logic [PHY_NUM-1:0]          rx_phy_sel;
	logic [31:0]                 task_id_h;
	logic [31:0]                 task_id_l;
	logic [PHY_NUM-1:0][31:0]    timer_cnt;
	logic                        wb_cyc;
	logic                        wb_stb;
	logic                        wb_we;
	logic                        wb_adr;
	logic [31:0]                 wb_dat_i;
	logic [31:0]                 wb_dat_o;
	logic                        wb_ack;
	logic [15:0]                 lfsr = 16'd88;
	int                          cycles = 0;

	alink_rx_top uut (.*);
	rx_monitor mon (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		for (int i = 0; i < PHY_NUM; i++)
			timer_cnt[i] <= timer_cnt[i] + 32'(i + 1);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// 16-bit fibonacci lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic load_task(input logic [PHY_NUM-1:0] chans);
		@(posedge clk);
		task_id_vld <= 1'b1;
		rx_phy_sel <= chans;
		task_id_h <= rand_bits(32);
		task_id_l <= rand_bits(32);
		@(posedge clk);
		task_id_vld <= 1'b0;
	endtask

	// all selected channels finish on the same cycle
	task automatic send_nonce(input logic [PHY_NUM-1:0] chans);
		logic [31:0] val [PHY_NUM];
		for (int i = 0; i < PHY_NUM; i++)
			val[i] = rand_bits(32);
		for (int b = 0; b < 32; b++) begin
			@(posedge clk);
			for (int i = 0; i < PHY_NUM; i++) begin
				if (chans[i]) begin
					rx_p[i] <= val[i][b];
					rx_n[i] <= !val[i][b];
				end
			end
			@(posedge clk);
			rx_p <= '0;
			rx_n <= '0;
			repeat (rand_bits(2)) @(posedge clk);
		end
	endtask

	task automatic bus_access(input logic we, input logic adr, output logic [31:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_i <= rand_bits(32);
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		data = wb_dat_o;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	// status read after a quiet gap, then pop that many words
	task automatic drain(input int n);
		logic [31:0] cnt;
		logic [31:0] d;
		int          got;
		got = 0;
		while (got < n) begin
			repeat (40) @(posedge clk);
			bus_access(1'b0, 1'b1, cnt);
			for (int k = 0; k < int'(cnt); k++) begin
				repeat (rand_bits(3)) @(posedge clk);
				bus_access(1'b0, 1'b0, d);
			end
			got += int'(cnt);
		end
	endtask

	initial begin
		int          c;
		logic [31:0] d;
		clk = 1'b0;
		rst = 1'b1;
		rx_p = '0;
		rx_n = '0;
		reg_flush = 1'b0;
		reg_mask = '0;
		reg_busy = '1;
		task_id_vld = 1'b0;
		rx_phy_sel = '0;
		task_id_h = '0;
		task_id_l = '0;
		timer_cnt = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 1'b0;
		wb_dat_i = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		repeat (8) begin	// one channel at a time
			c = int'(rand_bits(3) % 32'd5);
			load_task(5'(1 << c));
			send_nonce(5'(1 << c));
			drain(5);
		end
		load_task('1);
		send_nonce(5'b01010);	// two finish together
		drain(10);
		send_nonce('1);	// fills past almost full
		send_nonce('1);
		drain(50);

		@(posedge clk);
		reg_mask <= 5'b00100;
		send_nonce(5'b00101);
		drain(5);
		@(posedge clk);
		reg_busy <= 5'b01111;
		send_nonce(5'b10000);	// dropped, busy clear
		repeat (40) @(posedge clk);
		bus_access(1'b0, 1'b1, d);
		@(posedge clk);
		reg_flush <= 1'b1;
		@(posedge clk);
		reg_flush <= 1'b0;
		reg_mask <= '0;
		reg_busy <= '1;

		send_nonce(5'b01010);
		repeat (40) @(posedge clk);
		@(posedge clk);
		reg_flush <= 1'b1;
		@(posedge clk);
		reg_flush <= 1'b0;
		bus_access(1'b0, 1'b1, d);
		bus_access(1'b0, 1'b0, d);
		bus_access(1'b0, 1'b0, d);
		send_nonce(5'b00001);
		drain(5);

		bus_access(1'b1, 1'b0, d);	// writes only get an ack
		bus_access(1'b1, 1'b1, d);
		bus_access(1'b0, 1'b0, d);
		repeat (4) @(posedge clk);

		$display("errors %0d, cycles %0d", mon.errors, cycles);
		if (mon.errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
design/alink_pkg.sv
design/rx_phy.sv
design/rxc.sv
design/rx_fifo.sv
design/alink_rx_top.sv
tests/rx_monitor.sv
tests/tb_alink_rx.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir
verilator --binary --assert -f compile.f --top-module tb_alink_rx -o tb_alink_rx \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_alink_rx > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
